// ==== Makefile ====
# Verilator build and run for the i2si testbench

.PHONY: all lint clean

all: obj_dir/Vi2si_tb
	./obj_dir/Vi2si_tb | tee sim.log
	grep -q "sim passed" sim.log

obj_dir/Vi2si_tb: i2si.f hw/i2si_defs.svh hw/*.sv test/i2si_tb.sv
	verilator --binary --timing --assert --timescale 1ns/1ps -f i2si.f --top-module i2si_tb

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f i2si.f --top-module i2si_tb

clean:
	rm -rf obj_dir sim.log

// ==== hw/i2si_bist_gen.sv ====
`timescale 1ns/1ps
`include "i2si_defs.svh"

module i2si_bist_gen
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    step,          // once per stereo frame
    input  i2si_pkg::bist_cfg_t     bist_cfg,
    output logic [`I2SI_BIST_W-1:0] bist_value     // held between steps
);

    logic                    first_q;              // next step loads start
    logic [`I2SI_BIST_W-1:0] value_q;
    logic [`I2SI_BIST_W-1:0] value_add;

    assign value_add = value_q + `I2SI_BIST_W'(bist_cfg.inc);  // wraps mod 2^12

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            first_q <= 1'b1;
            value_q <= '0;
        end
        else if (!bist_cfg.en)
        begin
            first_q <= 1'b1;                       // re-arm for the next test run
        end
        else if (step)
        begin
            first_q <= 1'b0;
            if (first_q)
                value_q <= bist_cfg.start;
            else if (value_q >= bist_cfg.limit)
                value_q <= bist_cfg.start;         // wrap back
            else
                value_q <= value_add;
        end
    end

    assign bist_value = value_q;

endmodule

// ==== hw/i2si_defs.svh ====
`ifndef I2SI_DEFS_SVH
`define I2SI_DEFS_SVH

// bits per channel word on the serial link
`define I2SI_WORD_W 32

// width of the saw-tooth test value
`define I2SI_BIST_W 12

// host register address width
`define I2SI_ADDR_W 2

// increment field keeps the narrow 8-bit step
`define I2SI_INC_W 8

// host data bus width
`define I2SI_DATA_W 16

`endif

// ==== hw/i2si_deser.sv ====
`timescale 1ns/1ps
`include "i2si_defs.svh"

module i2si_deser
(
    input  logic              clk,
    input  logic              rst,
    input  logic              sck_rise,       // capture strobe
    input  logic              ws_s,           // 0 left, 1 right
    input  logic              sd_s,           // serial data, msb first
    output logic              frame_done,     // pulse after a right word closes
    output i2si_pkg::sample_t rx_sample       // last complete pair
);

    logic [`I2SI_WORD_W-1:0] shift_q;         // word being assembled
    logic [`I2SI_WORD_W-1:0] shift_nxt;       // word including this bit
    logic [`I2SI_WORD_W-1:0] left_q;          // finished left word
    logic                    ws_prev;         // ws level at the previous capture
    logic                    ws_edge;         // this bit is the lsb of the old channel

    // one-bit delay: ws moves one bit ahead of the msb, so the bit taken
    // with the new ws level still belongs to the old channel
    assign shift_nxt = {shift_q[`I2SI_WORD_W-2:0], sd_s};
    assign ws_edge   = sck_rise && (ws_s != ws_prev);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            ws_prev    <= 1'b0;
            frame_done <= 1'b0;
        end
        else
        begin
            frame_done <= ws_edge && ws_prev;       // right word closed
            if (sck_rise)
            begin
                ws_prev <= ws_s;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (sck_rise)
        begin
            shift_q <= shift_nxt;                  // full word shifts out old bits
        end
        if (ws_edge && !ws_prev)
        begin
            left_q <= shift_nxt;                   // left done, wait for right
        end
        if (ws_edge && ws_prev)
        begin
            rx_sample.left  <= left_q;
            rx_sample.right <= shift_nxt;          // pair complete
        end
    end

    // words are 32 sck periods long, so closes are far apart
    a_done_single: assert property (@(posedge clk) disable iff (!rst)
        frame_done |=> !frame_done);

endmodule

// ==== hw/i2si_out_stage.sv ====
`timescale 1ns/1ps
`include "i2si_defs.svh"

module i2si_out_stage
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    frame_done,    // new pair from the deserializer
    input  logic                    bist_mode,     // 1 sends the test value
    input  logic                    out_ack,
    input  logic                    clr_overrun,   // control register write
    input  i2si_pkg::sample_t       rx_sample,
    input  logic [`I2SI_BIST_W-1:0] bist_value,
    output logic                    out_req,
    output logic                    overrun,       // sticky, a frame was dropped
    output i2si_pkg::sample_t       out_sample
);

    import i2si_pkg::*;

    out_state_e              state_q;
    logic                    pend_q;               // frame taken, test value settling
    logic                    drop;                 // frame arrives while busy
    sample_t                 audio_q;              // received pair held for loading
    logic [`I2SI_WORD_W-1:0] bist_word;

    assign bist_word = `I2SI_WORD_W'(bist_value);  // zero-extend into each channel
    assign drop      = frame_done && ((state_q != OUT_IDLE) || pend_q);
    assign out_req   = (state_q == OUT_REQ);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state_q <= OUT_IDLE;
            pend_q  <= 1'b0;
            overrun <= 1'b0;
        end
        else
        begin
            if (clr_overrun)
                overrun <= 1'b0;
            if (drop)
                overrun <= 1'b1;                   // a drop in the same cycle wins
            pend_q <= frame_done && (state_q == OUT_IDLE) && !pend_q;
            case (state_q)
                OUT_IDLE:     if (pend_q) state_q <= OUT_REQ;
                OUT_REQ:      if (out_ack) state_q <= OUT_WAIT_LOW;
                OUT_WAIT_LOW: if (!out_ack) state_q <= OUT_IDLE;
                default:      state_q <= OUT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (frame_done && !drop)
            audio_q <= rx_sample;                  // only valid during the pulse
        if (pend_q)
            out_sample <= bist_mode ? {bist_word, bist_word} : audio_q;
    end

    a_hold_sample: assert property (@(posedge clk) disable iff (!rst)
        (out_req && $past(out_req)) |-> $stable(out_sample));

endmodule

// ==== hw/i2si_pkg.sv ====
`include "i2si_defs.svh"

package i2si_pkg;

    // host register map
    typedef enum logic [`I2SI_ADDR_W-1:0] {
        REG_CTRL       = 2'd0,                     // bit 0 is test enable
        REG_BIST_START = 2'd1,                     // saw-tooth start value
        REG_BIST_INC   = 2'd2,                     // saw-tooth step
        REG_BIST_LIMIT = 2'd3                      // saw-tooth upper limit
    } reg_addr_e;

    // consumer handshake states
    typedef enum logic [1:0] {
        OUT_IDLE     = 2'd0,                       // ready for a frame
        OUT_REQ      = 2'd1,                       // req high, waiting for ack
        OUT_WAIT_LOW = 2'd2                        // req low, waiting for ack to drop
    } out_state_e;

    typedef struct packed {
        logic                    write;            // 1 write, 0 read
        reg_addr_e               addr;             // target register
        logic [`I2SI_DATA_W-1:0] wdata;            // write data
    } reg_cmd_t;

    typedef struct packed {
        logic                    en;               // test mode
        logic [`I2SI_BIST_W-1:0] start;            // first value and wrap target
        logic [`I2SI_INC_W-1:0]  inc;              // step per frame
        logic [`I2SI_BIST_W-1:0] limit;            // wrap at or above this
    } bist_cfg_t;

    typedef struct packed {
        logic [`I2SI_WORD_W-1:0] left;             // ws low channel
        logic [`I2SI_WORD_W-1:0] right;            // ws high channel
    } sample_t;

endpackage

// ==== hw/i2si_reg_decode.sv ====
`timescale 1ns/1ps
`include "i2si_defs.svh"

module i2si_reg_decode
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    host_req,     // four-phase request level
    input  i2si_pkg::reg_cmd_t      host_cmd,     // held stable while req is high
    output logic                    host_ack,
    output logic [`I2SI_DATA_W-1:0] host_rdata,   // valid while ack is high
    output i2si_pkg::bist_cfg_t     bist_cfg,     // live register contents
    output logic                    cfg_write     // pulse on a control write
);

    import i2si_pkg::*;

    bist_cfg_t cfg_q;                              // register storage
    logic      new_req;                            // req up, ack not yet given
    logic      do_write;

    assign new_req  = host_req && !host_ack;
    assign do_write = new_req && host_cmd.write;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            host_ack   <= 1'b0;
            host_rdata <= '0;
            cfg_q      <= '0;
            cfg_write  <= 1'b0;
        end
        else
        begin
            cfg_write <= do_write && (host_cmd.addr == REG_CTRL);
            if (new_req)
            begin
                host_ack <= 1'b1;                  // one access per handshake
                if (host_cmd.write)
                begin
                    case (host_cmd.addr)
                        REG_CTRL:       cfg_q.en    <= host_cmd.wdata[0];
                        REG_BIST_START: cfg_q.start <= host_cmd.wdata[`I2SI_BIST_W-1:0];
                        REG_BIST_INC:   cfg_q.inc   <= host_cmd.wdata[`I2SI_INC_W-1:0];
                        REG_BIST_LIMIT: cfg_q.limit <= host_cmd.wdata[`I2SI_BIST_W-1:0];
                        default:        cfg_q       <= cfg_q;
                    endcase
                    host_rdata <= '0;              // writes return zero
                end
                else
                begin
                    // readback zero-extends each field to the bus width
                    case (host_cmd.addr)
                        REG_CTRL:       host_rdata <= `I2SI_DATA_W'(cfg_q.en);
                        REG_BIST_START: host_rdata <= `I2SI_DATA_W'(cfg_q.start);
                        REG_BIST_INC:   host_rdata <= `I2SI_DATA_W'(cfg_q.inc);
                        REG_BIST_LIMIT: host_rdata <= `I2SI_DATA_W'(cfg_q.limit);
                        default:        host_rdata <= '0;
                    endcase
                end
            end
            else if (!host_req && host_ack)
            begin
                host_ack <= 1'b0;                  // close the handshake
            end
        end
    end

    assign bist_cfg = cfg_q;

    // the host may drop req as soon as it sees ack, so look at req one cycle back
    a_ack_rise: assert property (@(posedge clk) disable iff (!rst)
        $rose(host_ack) |-> $past(host_req));
    a_ack_fall: assert property (@(posedge clk) disable iff (!rst)
        $fell(host_ack) |-> !$past(host_req));

endmodule

// ==== hw/i2si_sck_sync.sv ====
`timescale 1ns/1ps

module i2si_sck_sync
(
    input  logic clk,
    input  logic rst,
    input  logic sck,                              // raw serial clock pin
    input  logic ws,                               // raw word select pin
    input  logic sd,                               // raw serial data pin
    output logic sck_rise,                         // one clk pulse per sck rising edge
    output logic ws_s,                             // ws re-timed to clk
    output logic sd_s                              // sd re-timed to clk
);

    logic [2:0] sck_q;                             // [1] is safe to use, [2] is its delay
    logic [1:0] ws_q;
    logic [1:0] sd_q;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            sck_q    <= 3'b000;
            ws_q     <= 2'b00;
            sd_q     <= 2'b00;
            sck_rise <= 1'b0;
        end
        else
        begin
            sck_q    <= {sck_q[1:0], sck};         // shift in at bit 0
            ws_q     <= {ws_q[0], ws};
            sd_q     <= {sd_q[0], sd};
            sck_rise <= sck_q[1] && !sck_q[2];     // registered edge, clean pulse
        end
    end

    assign ws_s = ws_q[1];                         // two stages
    assign sd_s = sd_q[1];

    // sck is far slower than clk, so an edge never spans two cycles
    a_rise_single: assert property (@(posedge clk) disable iff (!rst)
        sck_rise |=> !sck_rise);

endmodule

// ==== hw/i2si_top.sv ====
`timescale 1ns/1ps
`include "i2si_defs.svh"

module i2si_top
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    sck,           // i2s pins
    input  logic                    ws,
    input  logic                    sd,
    input  logic                    host_req,
    input  i2si_pkg::reg_cmd_t      host_cmd,
    output logic                    host_ack,
    output logic [`I2SI_DATA_W-1:0] host_rdata,
    input  logic                    out_ack,
    output logic                    out_req,
    output i2si_pkg::sample_t       out_sample,
    output logic                    overrun
);

    import i2si_pkg::*;

    logic                    sck_rise;
    logic                    ws_s;
    logic                    sd_s;
    logic                    frame_done;
    logic                    cfg_write;            // clears overrun
    sample_t                 rx_sample;
    bist_cfg_t               bist_cfg;
    logic [`I2SI_BIST_W-1:0] bist_value;

    i2si_sck_sync i_sync (.clk(clk), .rst(rst), .sck(sck), .ws(ws), .sd(sd),
        .sck_rise(sck_rise), .ws_s(ws_s), .sd_s(sd_s));
    i2si_reg_decode i_regs (.clk(clk), .rst(rst), .host_req(host_req),
        .host_cmd(host_cmd), .host_ack(host_ack), .host_rdata(host_rdata),
        .bist_cfg(bist_cfg), .cfg_write(cfg_write));
    i2si_deser i_deser (.clk(clk), .rst(rst), .sck_rise(sck_rise), .ws_s(ws_s),
        .sd_s(sd_s), .frame_done(frame_done), .rx_sample(rx_sample));
    i2si_bist_gen i_bist (.clk(clk), .rst(rst), .step(frame_done),
        .bist_cfg(bist_cfg), .bist_value(bist_value));
    i2si_out_stage i_out (.clk(clk), .rst(rst), .frame_done(frame_done),
        .bist_mode(bist_cfg.en), .out_ack(out_ack), .clr_overrun(cfg_write),
        .rx_sample(rx_sample), .bist_value(bist_value), .out_req(out_req),
        .overrun(overrun), .out_sample(out_sample));

endmodule

// ==== i2si.f ====
+incdir+hw
hw/i2si_pkg.sv
hw/i2si_sck_sync.sv
hw/i2si_reg_decode.sv
hw/i2si_deser.sv
hw/i2si_bist_gen.sv
hw/i2si_out_stage.sv
hw/i2si_top.sv
test/i2si_tb.sv

// ==== test/i2si_tb.sv ====
`timescale 1ns/1ps
`include "i2si_defs.svh"

module i2si_tb;

    import i2si_pkg::*;

    typedef struct packed {
        logic                    mode;             // 1 saw-tooth, 0 audio
        logic [`I2SI_BIST_W-1:0] start;
        logic [`I2SI_INC_W-1:0]  inc;
        logic [`I2SI_BIST_W-1:0] limit;
        logic [7:0]              frames;           // frames serialized
        logic                    hold;             // long ack on the first sample
        logic [7:0]              n_out;            // samples that must come out
    } row_t;

    logic                    clk, rst;
    logic                    sck, ws, sd;          // i2s pins
    logic                    host_req, host_ack;
    reg_cmd_t                host_cmd;
    logic [`I2SI_DATA_W-1:0] host_rdata;
    logic                    out_req, out_ack, overrun;
    sample_t                 out_sample;
    row_t                    rows [0:6];
    sample_t                 exp_q [$];            // expected pairs oldest first
    logic [31:0]             rng = 32'hdad;        // lcg state
    logic [`I2SI_BIST_W-1:0] model_v;              // saw-tooth model value
    logic                    model_first;          // next frame loads start
    int                      errors = 0;
    int                      timeouts = 0;

    i2si_top i_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;                     // 4 ns period
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // poll out_req or host_ack on falling edges until it reaches level
    task automatic wait_level(input logic use_req, input logic level, input int limit,
                              input string what);
        int cnt;
        cnt = 0;
        while ((use_req ? out_req : host_ack) !== level && cnt < limit)
        begin
            @(negedge clk);
            cnt++;
        end
        if ((use_req ? out_req : host_ack) !== level)
        begin
            timeouts++;
            $display("timeout at %0t ns: %s", $time, what);
        end
    endtask

    // one four-phase host access where d is the expected readback on reads
    task automatic reg_access(input logic wr, input reg_addr_e a, input logic [15:0] d);
        @(negedge clk);
        host_cmd = '{wr, a, wr ? d : 16'h0000};
        host_req = 1'b1;
        wait_level(1'b0, 1'b1, 50, "host_ack did not rise");
        if (!wr && host_rdata !== d)
        begin
            errors++;
            $display("CHECK FAILED at %0t ns: reg %0d read %h expected %h",
                     $time, a, host_rdata, d);
        end
        host_req = 1'b0;
        wait_level(1'b0, 1'b0, 50, "host_ack did not fall");
    endtask

    // serialize one pair with sck at clk/8 and ws one bit ahead of the msb
    task automatic send_frame(input sample_t s);
        logic [63:0] bits;
        bits = {s.left, s.right};
        for (int i = 0; i < 64; i++)
        begin
            @(negedge clk);
            sck = 1'b0;                            // data and ws move on sck fall
            sd  = bits[63-i];
            ws  = (i >= 31) && (i < 63);           // flips on the lsb of each word
            repeat (4) @(negedge clk);
            sck = 1'b1;
            repeat (3) @(negedge clk);
        end
        @(negedge clk);
        sck = 1'b0;
    endtask

    task automatic feed_row(input row_t r);
        sample_t                 audio;
        logic [`I2SI_WORD_W-1:0] w;
        for (int f = 0; f < int'(r.frames); f++)
        begin
            rng = lcg_next(rng);
            audio.left = rng;
            rng = lcg_next(rng);
            audio.right = rng;
            if (model_first || model_v >= r.limit)
                model_v = r.start;                 // first step or wrap
            else
                model_v = model_v + {4'h0, r.inc}; // rolls over at 12 bits
            model_first = 1'b0;
            w = `I2SI_WORD_W'(model_v);
            exp_q.push_back(r.mode ? sample_t'({w, w}) : audio);
            send_frame(audio);                     // audio still runs in test mode
        end
    endtask

    task automatic consume_row(input row_t r);
        for (int n = 0; n < int'(r.n_out); n++)
        begin
            wait_level(1'b1, 1'b1, 3000, "out_req did not rise");
            if (out_req !== 1'b1)
                return;
            while (r.hold && exp_q.size() > 1 && exp_q[0] !== out_sample)
                void'(exp_q.pop_front());          // frames dropped under back-pressure
            if (exp_q.size() == 0 || exp_q[0] !== out_sample)
            begin
                errors++;
                $display("CHECK FAILED at %0t ns: sample %0d is %h", $time, n, out_sample);
            end
            else
                void'(exp_q.pop_front());
            out_ack = 1'b1;
            if (r.hold && n == 0)
                repeat (1280) @(negedge clk);      // about 2.5 frames of ack held high
            wait_level(1'b1, 1'b0, 50, "out_req did not fall");
            out_ack = 1'b0;
        end
    endtask

    initial
    begin
        logic prev_hold;
        rst = 1'b0;
        sck = 1'b0;
        ws = 1'b0;
        sd = 1'b0;
        host_req = 1'b0;
        host_cmd = '0;
        out_ack = 1'b0;
        prev_hold = 1'b0;
        // mode start inc limit frames hold samples_out
        rows[0] = '{1'b0, 12'h000, 8'h00, 12'h000, 8'd4, 1'b0, 8'd4};
        rows[1] = '{1'b1, 12'h010, 8'h08, 12'h028, 8'd8, 1'b0, 8'd8};  // wraps once
        rows[2] = '{1'b1, 12'h100, 8'h10, 12'h050, 8'd3, 1'b0, 8'd3};  // limit under start
        rows[3] = '{1'b1, 12'hff0, 8'h20, 12'hfff, 8'd4, 1'b0, 8'd4};
        rows[4] = '{1'b0, 12'h000, 8'h00, 12'h000, 8'd6, 1'b1, 8'd4};  // two frames lost
        rows[5] = '{1'b1, 12'h000, 8'h03, 12'h00a, 8'd7, 1'b1, 8'd5};
        rows[6] = '{1'b0, 12'h000, 8'h00, 12'h000, 8'd3, 1'b0, 8'd3};
        repeat (2) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        if (out_req !== 1'b0 || host_ack !== 1'b0 || overrun !== 1'b0)
        begin
            errors++;
            $display("CHECK FAILED at %0t ns: outputs not idle after reset", $time);
        end
        for (int a = 0; a < 4; a++)
            reg_access(1'b0, reg_addr_e'(a), 16'h0000);
        reg_access(1'b1, REG_BIST_START, 16'hfabc);
        reg_access(1'b1, REG_BIST_INC, 16'h125a);
        reg_access(1'b1, REG_BIST_LIMIT, 16'h0f00);
        reg_access(1'b1, REG_CTRL, 16'h0001);
        reg_access(1'b0, REG_BIST_START, 16'h0abc);  // fields keep only their own width
        reg_access(1'b0, REG_BIST_INC, 16'h005a);
        reg_access(1'b0, REG_BIST_LIMIT, 16'h0f00);
        reg_access(1'b0, REG_CTRL, 16'h0001);
        for (int r = 0; r < 7; r++)
        begin
            reg_access(1'b1, REG_BIST_START, 16'(rows[r].start));
            reg_access(1'b1, REG_BIST_INC, 16'(rows[r].inc));
            reg_access(1'b1, REG_BIST_LIMIT, 16'(rows[r].limit));
            if (overrun !== prev_hold)
            begin
                errors++;
                $display("CHECK FAILED at %0t ns: overrun %b before ctrl write", $time, overrun);
            end
            reg_access(1'b1, REG_CTRL, 16'h0000);    // also re-arms the first step
            if (overrun !== 1'b0)
            begin
                errors++;
                $display("CHECK FAILED at %0t ns: overrun not cleared by ctrl write", $time);
            end
            reg_access(1'b1, REG_CTRL, 16'(rows[r].mode));
            model_first = 1'b1;
            fork
                feed_row(rows[r]);
                consume_row(rows[r]);
            join
            repeat (20) @(negedge clk);
            if (out_req !== 1'b0 || exp_q.size() != 0)
            begin
                errors++;
                $display("CHECK FAILED at %0t ns: row %0d extra or missing samples", $time, r);
            end
            exp_q.delete();
            prev_hold = rows[r].hold;
        end
        $display("summary: %0d check errors %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule
